/* sources.f */
+incdir+hw
hw/rtp_pkg.sv
hw/scl_timer.sv
hw/i2c_rtp_master.sv
hw/touch_scanner.sv
hw/rtp_top.sv
test/ns2009_model.sv
test/rtp_tb.sv

/* Bender.yml */
package:
  name: rtp_ns2009

sources:
  - include_dirs:
      - hw
    files:
      - hw/rtp_pkg.sv
      - hw/scl_timer.sv
      - hw/i2c_rtp_master.sv
      - hw/touch_scanner.sv
      - hw/rtp_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/ns2009_model.sv
      - test/rtp_tb.sv

/* test/rtp_tb.sv */
// ----------------------------------------
// touch panel controller testbench
// table-driven scans against a panel model
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "rtp_defines.svh"

module rtp_tb;
    localparam int ROWS    = 7;
    localparam int TIMEOUT = 20000;   // about twice the length of one scan

    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [11:0] z;
        logic        nack;            // panel withholds ACK
        logic        twice;           // extra scan pulse mid-scan
        logic        exp_touched;
        logic        exp_err;
    } row_t;

    logic        clk, rst, scan, nack_en;
    logic [11:0] x_val, y_val, z_val;
    wire         sda, scl;
    logic [11:0] x, y, z1;
    logic        touched, valid, err;
    int          start_cnt, stop_cnt, viol_cnt;
    row_t        tab [ROWS];
    int          seed = 95828;
    int          mismatches = 0;
    int          timeouts = 0;
    int          starts0, stops0, exp_tx;
    logic [11:0] hold_x, hold_y, hold_z;   // last good results
    logic [31:0] rnd;
    bit          seen;

    rtp_top dut (
        .clk(clk), .rst(rst), .scan(scan), .sda(sda), .scl(scl),
        .x(x), .y(y), .z1(z1), .touched(touched), .valid(valid), .err(err)
    );

    ns2009_model u_panel (
        .clk(clk), .rst(rst), .nack_en(nack_en), .x_val(x_val), .y_val(y_val),
        .z_val(z_val), .sda(sda), .scl(scl), .start_cnt(start_cnt),
        .stop_cnt(stop_cnt), .viol_cnt(viol_cnt)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;   // 40 ns period

    function automatic row_t make_row(input logic [11:0] xv, input logic [11:0] yv,
                                      input logic [11:0] zv, input logic nk,
                                      input logic tw, input logic t, input logic e);
        make_row = {xv, yv, zv, nk, tw, t, e};
    endfunction

    // four-state compare so X or Z on an output never passes
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // polled once per cycle at the falling edge
    task automatic wait_for_valid(output bit got);
        int n;
        got = 1'b0;
        n = 0;
        while (!got && n < TIMEOUT) begin
            @(negedge clk);
            got = valid;
            n++;
        end
    endtask

    // bus and valid must stay quiet
    task automatic watch_quiet(input int cycles);
        int base;
        base = start_cnt;
        repeat (cycles) begin
            @(negedge clk);
            assert (!valid && start_cnt == base) else begin
                $display("MISMATCH %0t ns: new scan activity after valid", $time);
                mismatches++;
            end
        end
    endtask

    initial begin
        rst     = 1'b1;
        scan    = 1'b0;
        nack_en = 1'b0;
        x_val   = 12'h000;
        y_val   = 12'h000;
        z_val   = 12'h000;

        // threshold rows at, above and below the Z1 limit
        tab[0] = make_row(12'h123, 12'h456, 12'd700, 0, 0, 1, 0);
        tab[1] = make_row(12'hABC, 12'h0F1, `RTP_TOUCH_MIN, 0, 0, 0, 0);
        tab[2] = make_row(12'h800, 12'h7FF, `RTP_TOUCH_MIN + 12'd1, 0, 0, 1, 0);
        tab[3] = make_row(12'h001, 12'hFFE, `RTP_TOUCH_MIN - 12'd1, 0, 0, 0, 0);
        tab[4] = make_row(12'h555, 12'h666, 12'd900, 1, 0, 0, 1);  // touched kept
        rnd = $random(seed);
        tab[5].x = rnd[11:0];
        tab[5].y = rnd[27:16];
        rnd = $random(seed);
        tab[5].z = rnd[11:0];
        tab[5].nack = 1'b0;
        tab[5].twice = 1'b0;
        tab[5].exp_touched = (rnd[11:0] > `RTP_TOUCH_MIN);
        tab[5].exp_err = 1'b0;
        tab[6] = make_row(12'h3C3, 12'hC3C, 12'd2000, 0, 1, 1, 0);

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        repeat (20) begin
            @(negedge clk);
            assert (sda === 1'b1 && scl === 1'b1 && valid === 1'b0) else begin
                $display("MISMATCH %0t ns: bus or valid not idle after reset", $time);
                mismatches++;
            end
        end

        for (int r = 0; r < ROWS && timeouts == 0; r++) begin
            starts0 = start_cnt;
            stops0  = stop_cnt;
            @(posedge clk);
            x_val   <= tab[r].x;
            y_val   <= tab[r].y;
            z_val   <= tab[r].z;
            nack_en <= tab[r].nack;
            @(posedge clk);
            scan <= 1'b1;
            @(posedge clk);
            scan <= 1'b0;
            if (tab[r].twice) begin
                repeat (100) @(posedge clk);
                scan <= 1'b1;     // lands mid-scan
                @(posedge clk);
                scan <= 1'b0;
            end
            wait_for_valid(seen);
            assert (seen) else begin
                $display("timeout: valid never arrived for table row %0d", r);
                timeouts++;
            end
            if (seen) begin
                if (!tab[r].exp_err) begin
                    hold_x = tab[r].x;
                    hold_y = tab[r].y;
                    hold_z = tab[r].z;
                end
                exp_tx = tab[r].exp_err ? 1 : 6;   // nack aborts on the first write
                check_value("x", x, hold_x);
                check_value("y", y, hold_y);
                check_value("z1", z1, hold_z);
                check_value("err", err, tab[r].exp_err);
                check_value("touched", touched, tab[r].exp_touched);
                check_value("START count", start_cnt - starts0, exp_tx);
                check_value("STOP count", stop_cnt - stops0, exp_tx);
                if (tab[r].twice)
                    watch_quiet(200);
            end
        end

        check_value("SDA changes under SCL high", viol_cnt, 0);
        $display("%0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/ns2009_model.sv */
// ----------------------------------------
// NS2009 touch panel slave model
// I2C slave with pull-ups and a bus checker
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ns2009_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        nack_en,    // withhold every ACK
    input  logic [11:0] x_val,
    input  logic [11:0] y_val,
    input  logic [11:0] z_val,
    inout  wire         sda,
    inout  wire         scl,
    output int          start_cnt,
    output int          stop_cnt,
    output int          viol_cnt    // SDA moved under SCL high
);
    logic        sda_drv;           // 1 pulls SDA low
    logic        scl_p, sda_p;      // previous samples
    logic        active;            // between START and STOP
    logic [3:0]  bit_cnt;           // SCL rises in this frame
    logic [2:0]  byte_idx;          // 0 = address byte
    logic [7:0]  rx_sh;
    logic [7:0]  last_cmd;
    logic        addressed, is_read;
    logic        m_ack;             // master ACK of the last read byte
    logic [15:0] tx_sh;             // read word, msb first

    // weak pull-ups of the panel board
    pullup pu_sda (sda);
    pullup pu_scl (scl);
    assign sda = sda_drv ? 1'b0 : 1'bz;

    // sampled mid-cycle, away from the DUT clock edge
    always_ff @(negedge clk) begin
        if (rst) begin
            scl_p     <= 1'b1;
            sda_p     <= 1'b1;
            sda_drv   <= 1'b0;
            active    <= 1'b0;
            bit_cnt   <= 4'd0;
            byte_idx  <= 3'd0;
            addressed <= 1'b0;
            is_read   <= 1'b0;
            m_ack     <= 1'b0;
            last_cmd  <= 8'h00;
            tx_sh     <= 16'h0000;
            start_cnt <= 0;
            stop_cnt  <= 0;
            viol_cnt  <= 0;
        end else begin
            scl_p <= scl;
            sda_p <= sda;
            if (scl_p && scl && (sda_p != sda)) begin
                if (!active && !sda) begin
                    start_cnt <= start_cnt + 1;   // START
                    active    <= 1'b1;
                    bit_cnt   <= 4'd0;
                    byte_idx  <= 3'd0;
                    addressed <= 1'b0;
                end else if (active && bit_cnt == 4'd1 && sda) begin
                    stop_cnt <= stop_cnt + 1;     // STOP opens a new frame
                    active   <= 1'b0;
                    sda_drv  <= 1'b0;
                end else begin
                    viol_cnt <= viol_cnt + 1;
                end
            end else if (active && !scl_p && scl) begin
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt < 4'd8)
                    rx_sh <= {rx_sh[6:0], sda};
                else
                    m_ack <= !sda;                // only used in read frames
            end else if (active && scl_p && !scl) begin
                if (bit_cnt == 4'd8) begin
                    sda_drv <= 1'b0;
                    if (byte_idx == 3'd0) begin
                        addressed <= (rx_sh[7:1] == 7'h48) && !nack_en;
                        is_read   <= rx_sh[0];
                        sda_drv   <= (rx_sh[7:1] == 7'h48) && !nack_en;
                        case (last_cmd)
                            8'hC0:   tx_sh <= {x_val, 4'h0};
                            8'hD0:   tx_sh <= {y_val, 4'h0};
                            default: tx_sh <= {z_val, 4'h0};
                        endcase
                    end else if (addressed && !is_read) begin
                        last_cmd <= rx_sh;        // command byte
                        sda_drv  <= !nack_en;
                    end
                end else if (bit_cnt == 4'd9) begin
                    bit_cnt  <= 4'd0;
                    byte_idx <= byte_idx + 3'd1;
                    if (addressed && is_read && byte_idx < 3'd2 &&
                        (byte_idx == 3'd0 || m_ack)) begin
                        sda_drv <= !tx_sh[15];    // first bit of a data byte
                        tx_sh   <= {tx_sh[14:0], 1'b0};
                    end else begin
                        sda_drv <= 1'b0;
                    end
                end else if (addressed && is_read && byte_idx != 3'd0) begin
                    sda_drv <= !tx_sh[15];
                    tx_sh   <= {tx_sh[14:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rtp_top.sv */
// ----------------------------------------
// NS2009 touch panel controller top
// scanner, I2C master, SCL timer, pads
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rtp_top
    import rtp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        scan,
    inout  wire         sda,
    inout  wire         scl,
    output logic [11:0] x,
    output logic [11:0] y,
    output logic [11:0] z1,
    output logic        touched,
    output logic        valid,
    output logic        err
);
    logic       load, rd, busy, done, nack;
    logic       tick, half_tick;
    logic       sda_oe, scl_oe;
    logic [7:0] cmd;
    rtp_rx_u    rx;

    // open drain, pull-ups are external
    assign sda = sda_oe ? 1'b0 : 1'bz;
    assign scl = scl_oe ? 1'b0 : 1'bz;

    touch_scanner u_scanner (
        .clk(clk), .rst(rst), .scan(scan), .busy(busy), .done(done), .nack(nack),
        .rx(rx), .load(load), .rd(rd), .cmd(cmd), .x(x), .y(y), .z1(z1),
        .touched(touched), .valid(valid), .err(err)
    );

    i2c_rtp_master u_master (
        .clk(clk), .rst(rst), .load(load), .rd(rd), .cmd(cmd), .tick(tick),
        .half_tick(half_tick), .sda_in(sda), .busy(busy), .done(done), .nack(nack),
        .rx(rx), .sda_oe(sda_oe), .scl_oe(scl_oe)
    );

    scl_timer u_timer (
        .clk(clk), .rst(rst), .run(busy), .tick(tick), .half_tick(half_tick)
    );

endmodule

`default_nettype wire

/* hw/touch_scanner.sv */
// ----------------------------------------
// touch scanner
// X, Y, Z1 measurement sequence per scan
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "rtp_defines.svh"

module touch_scanner
    import rtp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        scan,
    input  logic        busy,
    input  logic        done,
    input  logic        nack,
    input  rtp_rx_u     rx,
    output logic        load,
    output logic        rd,
    output logic [7:0]  cmd,
    output logic [11:0] x,
    output logic [11:0] y,
    output logic [11:0] z1,
    output logic        touched,
    output logic        valid,
    output logic        err
);
    logic [2:0]  step;       // even = command write, odd = read
    logic        running;
    logic        issued;     // load given, waiting for done
    logic [7:0]  cmd_sel;
    logic [11:0] x_h, y_h;   // held until the whole scan succeeds

    always_comb begin
        case (step[2:1])
            2'd0:    cmd_sel = `RTP_CMD_X;
            2'd1:    cmd_sel = `RTP_CMD_Y;
            default: cmd_sel = `RTP_CMD_Z1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step    <= 3'd0;
            running <= 1'b0;
            issued  <= 1'b0;
            load    <= 1'b0;
            valid   <= 1'b0;
            err     <= 1'b0;
            touched <= 1'b0;
        end else begin
            load  <= 1'b0;
            valid <= 1'b0;
            if (!running) begin
                if (scan) begin
                    running <= 1'b1;
                    step    <= 3'd0;
                    issued  <= 1'b0;
                    err     <= 1'b0;
                end
            end else if (!issued && !busy) begin
                load   <= 1'b1;
                rd     <= step[0];
                cmd    <= cmd_sel;
                issued <= 1'b1;
            end else if (issued && done) begin
                issued <= 1'b0;
                step   <= step + 3'd1;
                if (nack) begin
                    err     <= 1'b1;   // abort, results untouched
                    valid   <= 1'b1;
                    running <= 1'b0;
                end else if (step == 3'd1) begin
                    x_h <= rx.meas.sample;
                end else if (step == 3'd3) begin
                    y_h <= rx.meas.sample;
                end else if (step == 3'd5) begin
                    x       <= x_h;
                    y       <= y_h;
                    z1      <= rx.meas.sample;
                    touched <= (rx.meas.sample > `RTP_TOUCH_MIN);
                    valid   <= 1'b1;
                    running <= 1'b0;
                end
            end
        end
    end

    a_load_idle: assert property (@(posedge clk) disable iff (rst) $rose(load) |-> !busy);

endmodule

`default_nettype wire

/* hw/i2c_rtp_master.sv */
// ----------------------------------------
// I2C master for the NS2009 touch panel
// one write or two-byte read per load strobe
// open-drain enables, slave ACK checking
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "rtp_defines.svh"

module i2c_rtp_master
    import rtp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,       // start one transaction
    input  logic       rd,         // 1 = read, 0 = command write
    input  logic [7:0] cmd,
    input  logic       tick,
    input  logic       half_tick,
    input  logic       sda_in,
    output logic       busy,
    output logic       done,       // one-cycle pulse after STOP
    output logic       nack,       // valid with done
    output rtp_rx_u    rx,         // valid with done on reads
    output logic       sda_oe,     // 1 pulls SDA low
    output logic       scl_oe      // 1 pulls SCL low
);
    rtp_state_e state;
    logic [1:0] ph;          // step within a bit
    logic [3:0] bit_cnt;     // 0..7 data, 8 = ACK slot
    logic [7:0] shreg;       // outgoing byte, msb first
    logic [7:0] cmd_q;
    logic       rd_q;
    logic       second;      // second read byte
    logic [1:0] sda_q;       // pad synchronizer
    logic       ack_slot;
    rtp_rx_u    rx_q;

    assign ack_slot = (bit_cnt == 4'd8);
    assign rx       = rx_q;

    always_ff @(posedge clk) begin
        sda_q <= {sda_q[0], sda_in};
    end

    // bit = tick: SCL low + set SDA, tick: release SCL, half_tick: sample
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            ph      <= 2'd0;
            bit_cnt <= 4'd0;
            second  <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            nack    <= 1'b0;
            sda_oe  <= 1'b0;
            scl_oe  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    sda_oe <= 1'b0;
                    scl_oe <= 1'b0;
                    if (load) begin
                        shreg   <= {`RTP_DEV_ADDR, rd};
                        cmd_q   <= cmd;
                        rd_q    <= rd;
                        nack    <= 1'b0;
                        busy    <= 1'b1;
                        ph      <= 2'd0;
                        bit_cnt <= 4'd0;
                        second  <= 1'b0;
                        state   <= start;
                    end
                end
                start: begin
                    if (tick) begin
                        sda_oe <= 1'b1;    // SDA falls, SCL still high
                        state  <= addr;
                    end
                end
                addr, write: begin
                    if (tick && ph == 2'd0) begin
                        scl_oe <= 1'b1;
                        sda_oe <= ack_slot ? 1'b0 : ~shreg[7];  // release for slave ACK
                        ph     <= 2'd1;
                    end else if (tick && ph == 2'd1) begin
                        scl_oe <= 1'b0;
                        ph     <= 2'd2;
                    end else if (half_tick && ph == 2'd2) begin
                        ph <= 2'd0;
                        if (!ack_slot) begin
                            shreg   <= {shreg[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 4'd1;
                        end else begin
                            bit_cnt <= 4'd0;
                            shreg   <= cmd_q;          // next byte on writes
                            if (sda_q[1]) begin
                                nack  <= 1'b1;         // no ACK, straight to STOP
                                state <= stop;
                            end else if (state == addr) begin
                                state <= rd_q ? read : write;
                            end else begin
                                state <= stop;
                            end
                        end
                    end
                end
                read: begin
                    if (tick && ph == 2'd0) begin
                        scl_oe <= 1'b1;
                        sda_oe <= ack_slot && !second;  // ACK first byte, NACK last
                        ph     <= 2'd1;
                    end else if (tick && ph == 2'd1) begin
                        scl_oe <= 1'b0;
                        ph     <= 2'd2;
                    end else if (half_tick && ph == 2'd2) begin
                        ph <= 2'd0;
                        if (!ack_slot) begin
                            bit_cnt <= bit_cnt + 4'd1;
                            if (!second)
                                rx_q.bytes.hi_byte <= {rx_q.bytes.hi_byte[6:0], sda_q[1]};
                            else
                                rx_q.bytes.lo_byte <= {rx_q.bytes.lo_byte[6:0], sda_q[1]};
                        end else begin
                            bit_cnt <= 4'd0;
                            second  <= 1'b1;
                            if (second)
                                state <= stop;
                        end
                    end
                end
                stop: begin
                    case (ph)
                        2'd0: if (tick) begin
                            scl_oe <= 1'b1;
                            sda_oe <= 1'b1;    // SDA low under SCL low
                            ph     <= 2'd1;
                        end
                        2'd1: if (tick) begin
                            scl_oe <= 1'b0;
                            ph     <= 2'd2;
                        end
                        2'd2: if (tick) begin
                            sda_oe <= 1'b0;    // SDA rises, the STOP itself
                            ph     <= 2'd3;
                        end
                        default: begin
                            ph    <= 2'd0;
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= idle;
                        end
                    endcase
                end
                default: state <= idle;
            endcase
        end
    end

    a_busy_state: assert property (@(posedge clk) disable iff (rst) (state == idle) == !busy);

    // data only moves under SCL low, START/STOP excepted
    a_sda_stable: assert property (@(posedge clk) disable iff (rst)
        $changed(sda_oe) |-> scl_oe || ($past(state) inside {start, stop}));

endmodule

`default_nettype wire

/* hw/scl_timer.sv */
// ----------------------------------------
// SCL timer
// tick per half SCL period, half_tick mid-way
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "rtp_defines.svh"

module scl_timer (
    input  logic clk,
    input  logic rst,
    input  logic run,        // master busy
    output logic tick,       // SCL edge point
    output logic half_tick   // mid-level sample point
);
    localparam int unsigned HALF = `RTP_SCL_HALF;
    localparam int unsigned CW   = $clog2(HALF);
    localparam logic [CW-1:0] LAST = CW'(HALF - 1);
    localparam logic [CW-1:0] MID  = CW'(HALF / 2 - 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            cnt       <= '0;       // parked at zero when idle
            tick      <= 1'b0;
            half_tick <= 1'b0;
        end else begin
            tick      <= (cnt == LAST);
            half_tick <= (cnt == MID);
            cnt       <= (cnt == LAST) ? '0 : cnt + 1'b1;
        end
    end

    a_strobes_apart: assert property (@(posedge clk) disable iff (rst) !(tick && half_tick));

endmodule

`default_nettype wire

/* hw/rtp_pkg.sv */
// ----------------------------------------
// touch panel controller types
// master FSM states, received read word
// ----------------------------------------
`default_nettype none

package rtp_pkg;

    typedef enum logic [3:0] {
        idle,   // bus released, waiting for load
        start,  // SDA falls with SCL high
        addr,   // address + r/w, slave ACK
        write,  // command byte, slave ACK
        read,   // two data bytes, master ACK/NACK
        stop    // SDA rises with SCL high
    } rtp_state_e;

    // the two bytes of a read, one word two views
    typedef union packed {
        struct packed {
            logic [7:0] hi_byte;  // first on the bus
            logic [7:0] lo_byte;
        } bytes;
        struct packed {
            logic [11:0] sample;  // msb first
            logic [3:0]  pad;     // low nibble, unused
        } meas;
    } rtp_rx_u;

endpackage

`default_nettype wire

/* hw/rtp_defines.svh */
// ----------------------------------------
// touch panel controller constants
// bus timing, NS2009 address and commands
// ----------------------------------------
`ifndef RTP_DEFINES_SVH
`define RTP_DEFINES_SVH

// system clocks per half SCL period, ~400 kHz SCL at 25 MHz
`define RTP_SCL_HALF 31

// 7-bit slave address (0x90 write, 0x91 read on the wire)
`define RTP_DEV_ADDR 7'h48

// measurement commands, 12-bit mode
`define RTP_CMD_X  8'hC0
`define RTP_CMD_Y  8'hD0
`define RTP_CMD_Z1 8'hE0

// Z1 pressure level above which the panel counts as touched
`define RTP_TOUCH_MIN 12'd300

`endif
